// File: rtl/pf_pkg.sv
/*
 * bitmap playfield shared definitions
 * widths, colour depth codes, fetch states, display word layout
 */
`default_nettype none

package pf_pkg;

    localparam int ADDR_W        = 16;                  // vram word address width
    localparam int WORD_W        = 16;                  // vram data word width
    localparam int COLOR_W       = 8;                   // colour index width
    localparam int HRES_W        = 11;                  // horizontal count width
    localparam int PIX_PER_GROUP = 8;                   // pixels per fetch group
    localparam int WORDS_MAX     = 4;                   // words per group at 8 bpp
    localparam int BUF_W         = PIX_PER_GROUP * COLOR_W;  // 64 bit pixel buffers

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [HRES_W-1:0]  hres_t;
    typedef logic [1:0]         bpp_t;

    localparam bpp_t BPP_1_ATTR = 2'd0;                 // 1 bpp, colours in the word
    localparam bpp_t BPP_4      = 2'd1;
    localparam bpp_t BPP_8      = 2'd2;
    localparam bpp_t BPP_XX     = 2'd3;                 // decodes as 8 bpp

    localparam hres_t H_SCANOUT_BEGIN = 11'd158;        // offscreen width less two

    localparam logic [2:0] FETCH_IDLE   = 3'd0;         // outside fetch window
    localparam logic [2:0] FETCH_ADDR   = 3'd1;         // word 0 address out
    localparam logic [2:0] FETCH_WAIT   = 3'd2;         // ram latency, word 1 address
    localparam logic [2:0] FETCH_READ_0 = 3'd3;
    localparam logic [2:0] FETCH_READ_1 = 3'd4;
    localparam logic [2:0] FETCH_READ_2 = 3'd5;
    localparam logic [2:0] FETCH_READ_3 = 3'd6;

    // one display word, raw pixels or 1 bpp with its own colours
    typedef union packed {
        word_t raw;                                     // 4 or 8 bpp pixel data
        struct packed {
            logic [3:0] back;                           // colour for clear bits
            logic [3:0] fore;                           // colour for set bits
            logic [7:0] pix;                            // pixel bits, msb first
        } attr;
    } disp_word_u;

endpackage

`default_nettype wire

// File: rtl/pf_words_if.sv
/*
 * display word handover
 * fetched words go from the fetch engine to the pixel shifter
 */
`default_nettype none
`timescale 1ns/100ps

interface pf_words_if;
    import pf_pkg::*;

    logic                            words_ready;       // one clock, words valid
    disp_word_u [WORDS_MAX-1:0]      words;             // previous group words
    logic                            buf_full;          // group buffer awaits load

    modport fetch (
        output words_ready,
        output words,
        input  buf_full
    );

    modport pixel (
        input  words_ready,
        input  words,
        output buf_full
    );

endinterface

`default_nettype wire

// File: rtl/pf_vram_fetch.sv
/*
 * playfield vram fetch engine
 * reads 1, 2 or 4 display words per eight pixel group and steps the
 * line start address by the line length with vertical repeat
 */
`default_nettype none
`timescale 1ns/100ps

module pf_vram_fetch (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           mem_fetch_i,        // fetch window of the line
    input  wire logic           mem_fetch_start_i,  // line fetch start strobe
    input  wire logic           end_of_line_i,
    input  wire logic           end_of_frame_i,
    input  wire logic           pf_blank_i,         // plane off, hold at frame start
    input  wire pf_pkg::addr_t  pf_start_addr_i,    // frame start word address
    input  wire pf_pkg::word_t  pf_line_len_i,      // words per display line
    input  wire pf_pkg::bpp_t   pf_bpp_i,
    input  wire logic [1:0]     pf_v_repeat_i,      // extra uses of each line
    input  wire pf_pkg::word_t  vram_data_i,        // valid one clock after select
    output      logic           vram_sel_o,
    output      pf_pkg::addr_t  vram_addr_o,
    pf_words_if.fetch           words
);
    import pf_pkg::*;

    logic [2:0] fetch_st;           // fsm state
    addr_t      disp_addr;          // next display word to read
    addr_t      line_start;         // first word of current line
    logic [1:0] v_count;            // repeats left on this line
    logic       first_group;        // first group of line has nothing to hand over
    logic       depth_8;            // four words per group
    logic       issue_rd;           // put disp_addr on the ram this clock

    assign depth_8 = (pf_bpp_i != BPP_1_ATTR) && (pf_bpp_i != BPP_4);

    // words 1 to 3 are addressed while earlier words return
    always_comb begin
        case (fetch_st)
            FETCH_ADDR:   issue_rd = mem_fetch_i && !words.buf_full;  // room for a group
            FETCH_WAIT:   issue_rd = (pf_bpp_i != BPP_1_ATTR);        // word 1
            FETCH_READ_0: issue_rd = depth_8;                         // word 2
            FETCH_READ_1: issue_rd = depth_8;                         // word 3
            default:      issue_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_st          <= FETCH_IDLE;
            vram_sel_o        <= 1'b0;
            vram_addr_o       <= '0;
            words.words_ready <= 1'b0;
            disp_addr         <= '0;
            line_start        <= '0;
            v_count           <= '0;
            first_group       <= 1'b0;
        end else begin
            vram_sel_o        <= issue_rd;              // one clock per word
            words.words_ready <= 1'b0;
            if (issue_rd) begin
                vram_addr_o <= disp_addr;
                disp_addr   <= disp_addr + 1'b1;        // words are consecutive
            end

            case (fetch_st)
                FETCH_IDLE: begin
                    if (mem_fetch_i) begin
                        fetch_st <= FETCH_ADDR;
                    end
                end
                FETCH_ADDR: begin
                    if (!mem_fetch_i) begin
                        fetch_st <= FETCH_IDLE;         // window closed
                    end else if (issue_rd) begin
                        fetch_st <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    words.words_ready <= !first_group;  // hand over previous group
                    first_group       <= 1'b0;
                    fetch_st          <= FETCH_READ_0;
                end
                FETCH_READ_0: begin
                    words.words[0] <= vram_data_i;
                    fetch_st <= (pf_bpp_i == BPP_1_ATTR) ? FETCH_ADDR : FETCH_READ_1;
                end
                FETCH_READ_1: begin
                    words.words[1] <= vram_data_i;
                    fetch_st <= (pf_bpp_i == BPP_4) ? FETCH_ADDR : FETCH_READ_2;
                end
                FETCH_READ_2: begin
                    words.words[2] <= vram_data_i;
                    fetch_st       <= FETCH_READ_3;
                end
                FETCH_READ_3: begin
                    words.words[3] <= vram_data_i;
                    fetch_st       <= FETCH_ADDR;       // group done
                end
                default: begin
                    fetch_st <= FETCH_IDLE;
                end
            endcase

            if (mem_fetch_start_i) begin
                disp_addr   <= line_start;              // line starts from its first word
                first_group <= 1'b1;
            end

            if (end_of_line_i) begin
                disp_addr <= line_start;                // rewind for a repeated line
                if (v_count != 2'd0) begin
                    v_count <= v_count - 1'b1;
                end else begin
                    v_count    <= pf_v_repeat_i;
                    line_start <= line_start + pf_line_len_i;  // next display line
                end
            end

            if (end_of_frame_i || pf_blank_i) begin
                disp_addr  <= pf_start_addr_i;          // back to top of frame
                line_start <= pf_start_addr_i;
                v_count    <= pf_v_repeat_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pf_scan_timing.sv
/*
 * playfield scanout timing
 * scanout window, horizontal pixel repeat and eight pixel group count
 */
`default_nettype none
`timescale 1ns/100ps

module pf_scan_timing (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           mem_fetch_i,
    input  wire logic           mem_fetch_start_i,
    input  wire logic           end_of_line_i,
    input  wire pf_pkg::hres_t  h_count_i,          // horizontal pixel count
    input  wire pf_pkg::hres_t  vid_left_i,         // left visible edge
    input  wire pf_pkg::hres_t  vid_right_i,        // right visible edge
    input  wire logic [1:0]     pf_h_repeat_i,      // extra clocks per pixel
    output      logic           scanout_o,          // window open
    output      logic           load_o,             // next group into shift register
    output      logic           shift_o,            // next pixel of group
    output      logic           end_o               // window closes
);
    import pf_pkg::*;

    hres_t      start_cnt;          // h count of first pixel load
    hres_t      end_cnt;            // h count of scanout end
    logic [1:0] h_cnt;              // repeat countdown of current pixel
    logic [2:0] px_cnt;             // pixel within group
    logic       start;              // window opens this clock
    logic       step;               // current pixel fully held

    assign start   = mem_fetch_i && (h_count_i == start_cnt);
    assign step    = scanout_o && (h_cnt == 2'd0);
    assign load_o  = start || (step && (px_cnt == 3'd7));   // every eighth step
    assign shift_o = !start && step && (px_cnt != 3'd7);
    assign end_o   = (h_count_i == end_cnt);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanout_o <= 1'b0;
            start_cnt <= '0;
            end_cnt   <= '0;
            h_cnt     <= '0;
            px_cnt    <= '0;
        end else begin
            if (step) begin
                h_cnt  <= pf_h_repeat_i;
                px_cnt <= px_cnt + 1'b1;                // wraps at group end
            end else if (scanout_o) begin
                h_cnt  <= h_cnt - 1'b1;
            end

            if (start) begin
                scanout_o <= 1'b1;
                h_cnt     <= pf_h_repeat_i;             // first pixel held too
                px_cnt    <= 3'd0;
            end

            if (end_o || end_of_line_i) begin
                scanout_o <= 1'b0;
            end

            if (mem_fetch_start_i) begin
                end_cnt <= H_SCANOUT_BEGIN + vid_right_i;
            end
            if (end_of_line_i) begin
                start_cnt <= H_SCANOUT_BEGIN + vid_left_i;  // for next line
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pf_pixel_shifter.sv
/*
 * playfield pixel shifter
 * expands display words into the group buffer, shifts pixels out,
 * shows border outside the window and applies the colour base
 */
`default_nettype none
`timescale 1ns/100ps

module pf_pixel_shifter (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           mem_fetch_start_i,  // new line, drop old buffer
    input  wire logic           load_i,
    input  wire logic           shift_i,
    input  wire logic           end_i,              // scanout window closes
    input  wire pf_pkg::bpp_t   pf_bpp_i,
    input  wire pf_pkg::color_t border_color_i,
    input  wire pf_pkg::color_t pf_colorbase_i,     // xor onto every index
    output      pf_pkg::color_t pf_color_index_o,
    pf_words_if.pixel           words
);
    import pf_pkg::*;

    logic [BUF_W-1:0] expand;       // group as eight indices, pixel 0 on top
    logic [BUF_W-1:0] pix_buf;      // next group waiting for load
    logic [BUF_W-1:0] pix_sr;       // group shifting out, head on top

    always_comb begin
        for (int i = 0; i < PIX_PER_GROUP; i++) begin
            color_t pix;
            case (pf_bpp_i)
                BPP_1_ATTR: begin                       // bit picks fore or back
                    pix = {4'h0, words.words[0].attr.pix[7-i] ? words.words[0].attr.fore
                                                               : words.words[0].attr.back};
                end
                BPP_4: begin                            // nibbles of words 0 and 1
                    pix = {4'h0, words.words[i/4].raw[15-4*(i%4) -: 4]};
                end
                default: begin                          // bytes of words 0 to 3
                    pix = words.words[i/2].raw[15-8*(i%2) -: 8];
                end
            endcase
            expand[BUF_W-1-i*COLOR_W -: COLOR_W] = pix;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            words.buf_full <= 1'b0;
            pix_sr         <= '0;
        end else begin
            if (words.words_ready) begin
                words.buf_full <= 1'b1;
                pix_buf        <= expand;
            end

            if (load_i) begin
                words.buf_full <= 1'b0;                 // fetch may read next group
                pix_sr         <= pix_buf;
            end else if (shift_i) begin
                pix_sr <= {pix_sr[BUF_W-COLOR_W-1:0], border_color_i};
            end

            if (mem_fetch_start_i) begin
                words.buf_full <= 1'b0;                 // stale group from last line
            end

            if (end_i || mem_fetch_start_i) begin
                pix_sr[BUF_W-1 -: COLOR_W] <= border_color_i;  // border until next load
            end
        end
    end

    assign pf_color_index_o = pix_sr[BUF_W-1 -: COLOR_W] ^ pf_colorbase_i;

endmodule

`default_nettype wire

// File: rtl/video_bitmap_playfield.sv
/*
 * bitmap playfield of the video controller
 * fetch engine, scanout timing and pixel shifter on plain ports
 */
`default_nettype none
`timescale 1ns/100ps

module video_bitmap_playfield (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           mem_fetch_i,        // line fetch window
    input  wire logic           mem_fetch_start_i,
    input  wire pf_pkg::hres_t  h_count_i,
    input  wire logic           end_of_line_i,
    input  wire logic           end_of_frame_i,
    input  wire pf_pkg::color_t border_color_i,
    input  wire pf_pkg::hres_t  vid_left_i,
    input  wire pf_pkg::hres_t  vid_right_i,
    output      logic           vram_sel_o,         // registered read select
    output      pf_pkg::addr_t  vram_addr_o,
    input  wire pf_pkg::word_t  vram_data_i,
    input  wire logic           pf_blank_i,
    input  wire pf_pkg::addr_t  pf_start_addr_i,
    input  wire pf_pkg::word_t  pf_line_len_i,
    input  wire pf_pkg::color_t pf_colorbase_i,
    input  wire pf_pkg::bpp_t   pf_bpp_i,
    input  wire logic [1:0]     pf_h_repeat_i,
    input  wire logic [1:0]     pf_v_repeat_i,
    output      pf_pkg::color_t pf_color_index_o
);

    logic load;                     // group load strobe
    logic shift;                    // pixel shift strobe
    logic scan_end;                 // window close strobe

    pf_words_if words_if ();

    pf_vram_fetch u_fetch (
        .clk                (clk),
        .reset_i            (reset_i),
        .mem_fetch_i        (mem_fetch_i),
        .mem_fetch_start_i  (mem_fetch_start_i),
        .end_of_line_i      (end_of_line_i),
        .end_of_frame_i     (end_of_frame_i),
        .pf_blank_i         (pf_blank_i),
        .pf_start_addr_i    (pf_start_addr_i),
        .pf_line_len_i      (pf_line_len_i),
        .pf_bpp_i           (pf_bpp_i),
        .pf_v_repeat_i      (pf_v_repeat_i),
        .vram_data_i        (vram_data_i),
        .vram_sel_o         (vram_sel_o),
        .vram_addr_o        (vram_addr_o),
        .words              (words_if)
    );

    pf_scan_timing u_timing (
        .clk                (clk),
        .reset_i            (reset_i),
        .mem_fetch_i        (mem_fetch_i),
        .mem_fetch_start_i  (mem_fetch_start_i),
        .end_of_line_i      (end_of_line_i),
        .h_count_i          (h_count_i),
        .vid_left_i         (vid_left_i),
        .vid_right_i        (vid_right_i),
        .pf_h_repeat_i      (pf_h_repeat_i),
        .scanout_o          (),                     // level kept inside timing
        .load_o             (load),
        .shift_o            (shift),
        .end_o              (scan_end)
    );

    pf_pixel_shifter u_shifter (
        .clk                (clk),
        .reset_i            (reset_i),
        .mem_fetch_start_i  (mem_fetch_start_i),
        .load_i             (load),
        .shift_i            (shift),
        .end_i              (scan_end),
        .pf_bpp_i           (pf_bpp_i),
        .border_color_i     (border_color_i),
        .pf_colorbase_i     (pf_colorbase_i),
        .pf_color_index_o   (pf_color_index_o),
        .words              (words_if)
    );

endmodule

`default_nettype wire

// File: dv/tb_video_bitmap_playfield.sv
/*
 * testbench for the bitmap playfield
 * random vram and settings, reference pixel model and line address model
 */
`default_nettype none
`timescale 1ns/100ps

module tb_video_bitmap_playfield;
    import pf_pkg::*;

    localparam int H_TOTAL      = 800;                  // clocks per line
    localparam int VID_LEFT     = 0;
    localparam int VID_RIGHT    = 640;
    localparam int FIRST_PIX    = int'(H_SCANOUT_BEGIN) + VID_LEFT + 1;  // one clock after start
    localparam int LAST_PIX     = int'(H_SCANOUT_BEGIN) + VID_RIGHT;     // border after this
    localparam int N_FRAMES     = 10;
    localparam int READ_TIMEOUT = 40;                   // clocks after fetch window opens

    logic           clk;
    logic           reset_i;
    logic           mem_fetch_i;
    logic           mem_fetch_start_i;
    hres_t          h_count_i;
    logic           end_of_line_i;
    logic           end_of_frame_i;
    color_t         border_color_i;
    hres_t          vid_left_i;
    hres_t          vid_right_i;
    logic           vram_sel_o;
    addr_t          vram_addr_o;
    word_t          vram_data_i;
    logic           pf_blank_i;
    addr_t          pf_start_addr_i;
    word_t          pf_line_len_i;
    color_t         pf_colorbase_i;
    bpp_t           pf_bpp_i;
    logic [1:0]     pf_h_repeat_i;
    logic [1:0]     pf_v_repeat_i;
    color_t         pf_color_index_o;

    word_t          vram [0:65535];                     // ram model contents
    integer         seed;
    int             err_count;
    addr_t          model_ls;                           // expected line start
    logic [1:0]     model_vcnt;                         // expected repeats left
    logic           rd_pend;                            // select seen last clock
    addr_t          rd_addr;

    video_bitmap_playfield UUT (
        .clk                (clk),
        .reset_i            (reset_i),
        .mem_fetch_i        (mem_fetch_i),
        .mem_fetch_start_i  (mem_fetch_start_i),
        .h_count_i          (h_count_i),
        .end_of_line_i      (end_of_line_i),
        .end_of_frame_i     (end_of_frame_i),
        .border_color_i     (border_color_i),
        .vid_left_i         (vid_left_i),
        .vid_right_i        (vid_right_i),
        .vram_sel_o         (vram_sel_o),
        .vram_addr_o        (vram_addr_o),
        .vram_data_i        (vram_data_i),
        .pf_blank_i         (pf_blank_i),
        .pf_start_addr_i    (pf_start_addr_i),
        .pf_line_len_i      (pf_line_len_i),
        .pf_colorbase_i     (pf_colorbase_i),
        .pf_bpp_i           (pf_bpp_i),
        .pf_h_repeat_i      (pf_h_repeat_i),
        .pf_v_repeat_i      (pf_v_repeat_i),
        .pf_color_index_o   (pf_color_index_o)
    );

    always #20 clk = ~clk;                              // 40 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping on value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    // index of pixel p of a line from the word layout
    function automatic color_t ref_pixel(input addr_t ls, input bpp_t bpp, input int p);
        int    grp;
        int    idx;
        word_t w;
        word_t sh;
        grp = p / PIX_PER_GROUP;
        idx = p % PIX_PER_GROUP;
        if (bpp == BPP_1_ATTR) begin
            w = vram[ls + addr_t'(grp)];                // one word per group
            sh = w >> (7 - idx);                        // pixel bit to lsb
            if (sh[0]) begin
                return {4'h0, w[11:8]};                 // fore
            end else begin
                return {4'h0, w[15:12]};                // back
            end
        end else if (bpp == BPP_4) begin
            w = vram[ls + addr_t'(2 * grp + idx / 4)];
            sh = w >> (12 - 4 * (idx % 4));             // msb nibble first
            return {4'h0, sh[3:0]};
        end else begin
            w = vram[ls + addr_t'(4 * grp + idx / 2)];  // code 3 lands here too
            sh = w >> (8 - 8 * (idx % 2));
            return sh[7:0];
        end
    endfunction

    task automatic fill_vram();
        logic [31:0] r;
        int          a;
        for (a = 0; a < 65536; a++) begin
            r = $random(seed);
            vram[addr_t'(a)] = r[15:0];
        end
    endtask

    // frames 1 to 3 pin the depth with no repeat and the rest are random
    task automatic apply_frame_settings(input int f);
        logic [31:0] r;
        r = $random(seed);
        if (f >= 1 && f <= 3) begin
            pf_bpp_i       = (f == 1) ? BPP_8 : ((f == 2) ? BPP_4 : BPP_1_ATTR);
            pf_h_repeat_i  = 2'd0;
            pf_colorbase_i = 8'h00;
        end else begin
            pf_bpp_i       = r[1:0];
            pf_h_repeat_i  = r[3:2];
            pf_colorbase_i = r[11:4];
        end
        pf_v_repeat_i  = r[13:12];
        border_color_i = r[21:14];
        r = $random(seed);
        pf_start_addr_i = r[15:0];
        pf_line_len_i   = r[31:16];                     // wraps in 64k words
    endtask

    // one line of video timing, ram replies and checks
    task automatic run_line(input bit display, input bit frame_end, input int next_frame);
        int     h;
        int     pix;
        bit     addr_seen;
        color_t exp;
        addr_seen = 1'b0;
        for (h = 0; h < H_TOTAL; h++) begin
            @(posedge clk);
            #2;
            h_count_i         = hres_t'(h);
            mem_fetch_start_i = (h == 2);
            mem_fetch_i       = (h >= 4) && (h <= H_TOTAL - 3);
            end_of_line_i     = (h == H_TOTAL - 1);
            end_of_frame_i    = frame_end && (h == H_TOTAL - 1);
            if (rd_pend) begin
                vram_data_i = vram[rd_addr];            // one clock after sampled select
            end
            if (frame_end && h == H_TOTAL - 1) begin
                apply_frame_settings(next_frame);       // taken with end of frame
            end

            @(negedge clk);
            rd_pend = vram_sel_o;
            rd_addr = vram_addr_o;
            if (!addr_seen && h >= 4 && vram_sel_o) begin
                check_value("vram_addr_o", 32'(vram_addr_o), 32'(model_ls));
                addr_seen = 1'b1;
            end else if (!addr_seen && h == 4 + READ_TIMEOUT) begin
                fail_timeout("no vram read within the fetch window of the line");
            end
            if (display && h >= FIRST_PIX && h <= LAST_PIX) begin
                pix = (h - FIRST_PIX) / (int'(pf_h_repeat_i) + 1);
                exp = ref_pixel(model_ls, pf_bpp_i, pix) ^ pf_colorbase_i;
                check_value("pf_color_index_o", 32'(pf_color_index_o), 32'(exp));
            end else if (h >= 3 && !(frame_end && h == H_TOTAL - 1)) begin
                exp = border_color_i ^ pf_colorbase_i;  // border outside the window
                check_value("pf_color_index_o", 32'(pf_color_index_o), 32'(exp));
            end
        end

        if (frame_end) begin
            model_ls   = pf_start_addr_i;               // top of next frame
            model_vcnt = pf_v_repeat_i;
        end else if (model_vcnt != 2'd0) begin
            model_vcnt = model_vcnt - 2'd1;             // same line again
        end else begin
            model_vcnt = pf_v_repeat_i;
            model_ls   = model_ls + pf_line_len_i;
        end
    endtask

    initial begin
        int          f;
        int          l;
        int          n_lines;
        logic [31:0] r;
        seed              = 64128;
        err_count         = 0;
        clk               = 1'b0;
        reset_i           = 1'b1;
        mem_fetch_i       = 1'b0;
        mem_fetch_start_i = 1'b0;
        h_count_i         = '0;
        end_of_line_i     = 1'b0;
        end_of_frame_i    = 1'b0;
        vid_left_i        = hres_t'(VID_LEFT);
        vid_right_i       = hres_t'(VID_RIGHT);
        vram_data_i       = '0;
        pf_blank_i        = 1'b0;
        apply_frame_settings(0);                        // random colour base for reset check
        model_ls          = '0;
        model_vcnt        = 2'd0;
        rd_pend           = 1'b0;
        rd_addr           = '0;
        fill_vram();

        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        check_value("vram_sel_o", 32'(vram_sel_o), 32'h0);
        check_value("vram_addr_o", 32'(vram_addr_o), 32'h0);
        check_value("pf_color_index_o", 32'(pf_color_index_o), 32'(pf_colorbase_i));

        // scanout start count is only set by the first end of line
        run_line(1'b0, 1'b1, 1);

        for (f = 1; f <= N_FRAMES; f++) begin
            r = $random(seed);
            n_lines = 2 + int'(r[1:0]);
            for (l = 0; l < n_lines; l++) begin
                run_line(1'b1, l == n_lines - 1, f + 1);
            end
        end

        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: video_bitmap_playfield.f
rtl/pf_pkg.sv
rtl/pf_words_if.sv
rtl/pf_vram_fetch.sv
rtl/pf_scan_timing.sv
rtl/pf_pixel_shifter.sv
rtl/video_bitmap_playfield.sv
dv/tb_video_bitmap_playfield.sv

// File: Makefile
# Verilator build and run of the bitmap playfield testbench

SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_video_bitmap_playfield
FILELIST = video_bitmap_playfield.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
